// ==== Makefile ====
# Verilator build and run of the COP testbench

TOP := tb_cop

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps \
		-f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
+incdir+rtl
rtl/cop_pkg.sv
rtl/cop_decode.sv
rtl/cop_execute.sv
rtl/cop_result.sv
rtl/cop_trace.sv
rtl/cop_top.sv
verif/tb_cop.sv

// ==== rtl/cop_config.svh ====
`ifndef COP_CONFIG_SVH
`define COP_CONFIG_SVH

// ----------------------------------------
// COP sizing and encoding constants
// ----------------------------------------

`define COP_XLEN      32                     // Data word width
`define COP_NUM_CPRS  16                     // Coprocessor register count
`define COP_CPR_AW    $clog2(`COP_NUM_CPRS)  // CPR address width
`define COP_MAJOR     7'b0001011             // custom-0 major opcode

`endif

// ==== rtl/cop_decode.sv ====
`timescale 1ns/1ps
`include "cop_config.svh"

module cop_decode (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   accept,      // Transfer on accept channel
    input  logic [`COP_XLEN-1:0]   insn_enc,
    input  logic [`COP_XLEN-1:0]   rs1,
    output logic                   dec_valid,   // Cycle 1 pulse
    output cop_pkg::cop_op_t       dec_op,
    output logic [`COP_CPR_AW-1:0] dec_crd,
    output logic [`COP_CPR_AW-1:0] dec_crs1,
    output logic [`COP_CPR_AW-1:0] dec_crs2,
    output logic [7:0]             dec_imm,
    output logic [4:0]             dec_rd,
    output logic [`COP_XLEN-1:0]   dec_rs1,
    output logic                   dec_illegal
);

    cop_pkg::cop_insn_t insn_q;    // Held encoding
    logic               imm_form;  // Immediate view in use

    // ----------------------------------------
    // Capture
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;  // One cycle behind acceptance
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            insn_q  <= insn_enc;
            dec_rs1 <= rs1;
        end
    end

    // ----------------------------------------
    // Field decode
    // ----------------------------------------

    assign dec_op   = cop_pkg::cop_op_t'(insn_q.r.funct);
    assign imm_form = (dec_op == cop_pkg::OP_RORI) || (dec_op == cop_pkg::OP_ADDI);

    // Fields common to both views
    assign dec_crd  = insn_q.r.crd;
    assign dec_crs1 = insn_q.r.crs1;
    assign dec_rd   = insn_q.r.rd;

    // Bits 27:20 are crs2 or imm8 depending on the op
    assign dec_crs2 = imm_form ? '0 : insn_q.r.crs2;
    assign dec_imm  = imm_form ? insn_q.i.imm8 : '0;

    // Wrong opcode space, or funct past the last op
    assign dec_illegal = (insn_q.r.major != `COP_MAJOR) ||
                         (insn_q.r.funct > 4'(cop_pkg::OP_ADDI));

endmodule

// ==== rtl/cop_execute.sv ====
`timescale 1ns/1ps
`include "cop_config.svh"

module cop_execute (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   dec_valid,
    input  cop_pkg::cop_op_t       dec_op,
    input  logic [`COP_CPR_AW-1:0] dec_crd,
    input  logic [`COP_CPR_AW-1:0] dec_crs1,
    input  logic [`COP_CPR_AW-1:0] dec_crs2,
    input  logic [7:0]             dec_imm,
    input  logic [4:0]             dec_rd,
    input  logic [`COP_XLEN-1:0]   dec_rs1,
    input  logic                   dec_illegal,
    input  logic [`COP_XLEN-1:0]   rd_data_a,   // CPR[crs1]
    input  logic [`COP_XLEN-1:0]   rd_data_b,   // CPR[crs2]
    output logic [`COP_CPR_AW-1:0] rd_addr_a,
    output logic [`COP_CPR_AW-1:0] rd_addr_b,
    output logic                   exe_valid,   // Cycle 2 pulse
    output cop_pkg::cop_result_t   exe_result,
    output logic                   exe_cpr_wen,
    output logic [`COP_CPR_AW-1:0] exe_crd,
    output logic [`COP_XLEN-1:0]   exe_value,
    output logic                   exe_gpr_wen,
    output logic [4:0]             exe_rd
);

    logic [2*`COP_XLEN-1:0] rot_wide;  // Doubled word for rotate
    logic [`COP_XLEN-1:0]   value;

    // Operand reads are combinational from the CPR file
    assign rd_addr_a = dec_crs1;
    assign rd_addr_b = dec_crs2;

    assign rot_wide = {rd_data_a, rd_data_a} >> dec_imm[4:0];

    // ----------------------------------------
    // Value select
    // ----------------------------------------

    always_comb begin
        case (dec_op)
            cop_pkg::OP_MV2COP: value = dec_rs1;
            cop_pkg::OP_MV2GPR: value = rd_data_a;
            cop_pkg::OP_ADD:    value = rd_data_a + rd_data_b;
            cop_pkg::OP_XOR:    value = rd_data_a ^ rd_data_b;
            cop_pkg::OP_RORI:   value = rot_wide[`COP_XLEN-1:0];  // Low half holds rotation
            cop_pkg::OP_ADDI:   value = rd_data_a + {{(`COP_XLEN-8){1'b0}}, dec_imm};
            default:            value = '0;  // Illegal funct
        endcase
    end

    // ----------------------------------------
    // Register stage
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (dec_valid) begin
            exe_value   <= value;
            exe_crd     <= dec_crd;
            exe_rd      <= dec_rd;
            exe_result  <= dec_illegal ? cop_pkg::RES_ILLEGAL : cop_pkg::RES_OK;
            // Only MV2GPR goes to the GPR side
            exe_cpr_wen <= !dec_illegal && (dec_op != cop_pkg::OP_MV2GPR);
            exe_gpr_wen <= !dec_illegal && (dec_op == cop_pkg::OP_MV2GPR);
        end
    end

endmodule

// ==== rtl/cop_pkg.sv ====
package cop_pkg;

    // ----------------------------------------
    // Instruction encoding, two views
    // ----------------------------------------

    // Register form, crs2 in bits 23:20
    typedef struct packed {
        logic [3:0] funct;  // Operation select
        logic [3:0] pad;    // Unused
        logic [3:0] crs2;
        logic [3:0] crs1;
        logic [3:0] crd;
        logic [4:0] rd;     // GPR destination
        logic [6:0] major;
    } cop_rtype_t;

    // Immediate form, imm8 over crs2 and pad
    typedef struct packed {
        logic [3:0] funct;
        logic [7:0] imm8;   // Zero-extended immediate
        logic [3:0] crs1;
        logic [3:0] crd;
        logic [4:0] rd;
        logic [6:0] major;
    } cop_itype_t;

    typedef union packed {
        cop_rtype_t r;
        cop_itype_t i;
    } cop_insn_t;

    // Operations, straight from funct
    typedef enum logic [3:0] {
        OP_MV2COP = 4'd0,   // crd <- rs1
        OP_MV2GPR = 4'd1,   // rd <- crs1
        OP_ADD    = 4'd2,
        OP_XOR    = 4'd3,
        OP_RORI   = 4'd4,
        OP_ADDI   = 4'd5
    } cop_op_t;

    // Result code on the response channel
    typedef enum logic [2:0] {
        RES_OK      = 3'd0,
        RES_ILLEGAL = 3'd1  // Bad major or funct, no writes
    } cop_result_t;

endpackage

// ==== rtl/cop_result.sv ====
`timescale 1ns/1ps
`include "cop_config.svh"

module cop_result (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   exe_valid,
    input  cop_pkg::cop_result_t   exe_result,
    input  logic                   exe_cpr_wen,
    input  logic [`COP_CPR_AW-1:0] exe_crd,
    input  logic [`COP_XLEN-1:0]   exe_value,
    input  logic                   exe_gpr_wen,
    input  logic [4:0]             exe_rd,
    input  logic [`COP_CPR_AW-1:0] rd_addr_a,
    input  logic [`COP_CPR_AW-1:0] rd_addr_b,
    input  logic [`COP_CPR_AW-1:0] snoop_addr,   // Trace read port
    input  logic                   cpu_insn_ack,
    output logic [`COP_XLEN-1:0]   rd_data_a,
    output logic [`COP_XLEN-1:0]   rd_data_b,
    output logic [`COP_XLEN-1:0]   snoop_data,
    output logic                   cop_insn_rsp,
    output logic [2:0]             cop_result,
    output logic                   cop_wen,
    output logic [4:0]             cop_waddr,
    output logic [`COP_XLEN-1:0]   cop_wdata,
    output logic                   rsp_done      // Response handshake this cycle
);

    logic [`COP_XLEN-1:0] cprs [`COP_NUM_CPRS];

    // ----------------------------------------
    // CPR file
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < `COP_NUM_CPRS; i++) begin
                cprs[i] <= '0;
            end
        end else if (exe_valid && exe_cpr_wen) begin
            cprs[exe_crd] <= exe_value;  // Visible from cycle 3
        end
    end

    // Three async read ports
    assign rd_data_a  = cprs[rd_addr_a];
    assign rd_data_b  = cprs[rd_addr_b];
    assign snoop_data = cprs[snoop_addr];

    // ----------------------------------------
    // Response channel
    // ----------------------------------------

    assign rsp_done = cop_insn_rsp && cpu_insn_ack;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cop_insn_rsp <= 1'b0;
            cop_result   <= '0;
            cop_wen      <= 1'b0;
        end else if (exe_valid) begin
            cop_insn_rsp <= 1'b1;        // Raised with the CPR write
            cop_result   <= exe_result;
            cop_wen      <= exe_gpr_wen;
        end else if (rsp_done) begin
            cop_insn_rsp <= 1'b0;
        end
    end

    // Payload held stable through back-pressure
    always_ff @(posedge g_clk) begin
        if (exe_valid) begin
            cop_waddr <= exe_rd;
            cop_wdata <= exe_value;
        end
    end

endmodule

// ==== rtl/cop_top.sv ====
`timescale 1ns/1ps
`include "cop_config.svh"

module cop_top (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 cpu_insn_req,
    input  logic [`COP_XLEN-1:0] cpu_insn_enc,
    input  logic [`COP_XLEN-1:0] cpu_rs1,
    input  logic                 cpu_insn_ack,    // Response accepted
    output logic                 cop_insn_ack,    // Request accepted
    output logic                 cop_insn_rsp,
    output logic [2:0]           cop_result,
    output logic                 cop_wen,
    output logic [4:0]           cop_waddr,
    output logic [`COP_XLEN-1:0] cop_wdata,
    output logic                 trace_valid,
    output logic [`COP_XLEN-1:0] trace_enc,
    output logic [`COP_XLEN-1:0] trace_rs1,
    output logic [2:0]           trace_result,
    output logic                 trace_wen,
    output logic [4:0]           trace_waddr,
    output logic [`COP_XLEN-1:0] trace_wdata,
    output logic [`COP_XLEN-1:0] trace_cpr_pre,
    output logic [`COP_XLEN-1:0] trace_cpr_post
);

    logic                   busy;      // One instruction in flight
    logic                   accept;
    logic                   rsp_done;

    // Decode to execute
    logic                   dec_valid;
    cop_pkg::cop_op_t       dec_op;
    logic [`COP_CPR_AW-1:0] dec_crd;
    logic [`COP_CPR_AW-1:0] dec_crs1;
    logic [`COP_CPR_AW-1:0] dec_crs2;
    logic [7:0]             dec_imm;
    logic [4:0]             dec_rd;
    logic [`COP_XLEN-1:0]   dec_rs1;
    logic                   dec_illegal;

    // Execute to result
    logic                   exe_valid;
    cop_pkg::cop_result_t   exe_result;
    logic                   exe_cpr_wen;
    logic [`COP_CPR_AW-1:0] exe_crd;
    logic [`COP_XLEN-1:0]   exe_value;
    logic                   exe_gpr_wen;
    logic [4:0]             exe_rd;

    // CPR read ports
    logic [`COP_CPR_AW-1:0] rd_addr_a;
    logic [`COP_CPR_AW-1:0] rd_addr_b;
    logic [`COP_CPR_AW-1:0] snoop_addr;
    logic [`COP_XLEN-1:0]   rd_data_a;
    logic [`COP_XLEN-1:0]   rd_data_b;
    logic [`COP_XLEN-1:0]   snoop_data;

    // ----------------------------------------
    // Accept handshake
    // ----------------------------------------

    assign cop_insn_ack = cpu_insn_req && !busy;  // Only answers a request
    assign accept       = cpu_insn_req && cop_insn_ack;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (rsp_done) begin
            busy <= 1'b0;  // Idle the cycle after handshake
        end
    end

    // ----------------------------------------
    // Stages
    // ----------------------------------------

    cop_decode u_decode (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .accept      (accept),
        .insn_enc    (cpu_insn_enc),
        .rs1         (cpu_rs1),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_crd     (dec_crd),
        .dec_crs1    (dec_crs1),
        .dec_crs2    (dec_crs2),
        .dec_imm     (dec_imm),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_illegal (dec_illegal)
    );

    cop_execute u_execute (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_crd     (dec_crd),
        .dec_crs1    (dec_crs1),
        .dec_crs2    (dec_crs2),
        .dec_imm     (dec_imm),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_illegal (dec_illegal),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .exe_valid   (exe_valid),
        .exe_result  (exe_result),
        .exe_cpr_wen (exe_cpr_wen),
        .exe_crd     (exe_crd),
        .exe_value   (exe_value),
        .exe_gpr_wen (exe_gpr_wen),
        .exe_rd      (exe_rd)
    );

    cop_result u_result (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .exe_valid    (exe_valid),
        .exe_result   (exe_result),
        .exe_cpr_wen  (exe_cpr_wen),
        .exe_crd      (exe_crd),
        .exe_value    (exe_value),
        .exe_gpr_wen  (exe_gpr_wen),
        .exe_rd       (exe_rd),
        .rd_addr_a    (rd_addr_a),
        .rd_addr_b    (rd_addr_b),
        .snoop_addr   (snoop_addr),
        .cpu_insn_ack (cpu_insn_ack),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .snoop_data   (snoop_data),
        .cop_insn_rsp (cop_insn_rsp),
        .cop_result   (cop_result),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .rsp_done     (rsp_done)
    );

    cop_trace u_trace (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .accept         (accept),
        .insn_enc       (cpu_insn_enc),
        .rs1            (cpu_rs1),
        .cop_result     (cop_result),
        .cop_wen        (cop_wen),
        .cop_waddr      (cop_waddr),
        .cop_wdata      (cop_wdata),
        .rsp_done       (rsp_done),
        .snoop_data     (snoop_data),
        .snoop_addr     (snoop_addr),
        .trace_valid    (trace_valid),
        .trace_enc      (trace_enc),
        .trace_rs1      (trace_rs1),
        .trace_result   (trace_result),
        .trace_wen      (trace_wen),
        .trace_waddr    (trace_waddr),
        .trace_wdata    (trace_wdata),
        .trace_cpr_pre  (trace_cpr_pre),
        .trace_cpr_post (trace_cpr_post)
    );

endmodule

// ==== rtl/cop_trace.sv ====
`timescale 1ns/1ps
`include "cop_config.svh"

module cop_trace (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   accept,
    input  logic [`COP_XLEN-1:0]   insn_enc,
    input  logic [`COP_XLEN-1:0]   rs1,
    input  logic [2:0]             cop_result,
    input  logic                   cop_wen,
    input  logic [4:0]             cop_waddr,
    input  logic [`COP_XLEN-1:0]   cop_wdata,
    input  logic                   rsp_done,
    input  logic [`COP_XLEN-1:0]   snoop_data,
    output logic [`COP_CPR_AW-1:0] snoop_addr,
    output logic                   trace_valid,     // One cycle per retire
    output logic [`COP_XLEN-1:0]   trace_enc,
    output logic [`COP_XLEN-1:0]   trace_rs1,
    output logic [2:0]             trace_result,
    output logic                   trace_wen,
    output logic [4:0]             trace_waddr,
    output logic [`COP_XLEN-1:0]   trace_wdata,
    output logic [`COP_XLEN-1:0]   trace_cpr_pre,
    output logic [`COP_XLEN-1:0]   trace_cpr_post
);

    cop_pkg::cop_insn_t insn_in;    // Incoming encoding
    cop_pkg::cop_insn_t insn_held;  // Encoding in flight

    assign insn_in   = insn_enc;
    assign insn_held = trace_enc;

    // Destination CPR, from the bus at accept and from the capture after
    assign snoop_addr = accept ? insn_in.r.crd : insn_held.r.crd;

    // ----------------------------------------
    // Retire transaction capture
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            trace_valid <= 1'b0;
        end else begin
            trace_valid <= rsp_done;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            trace_enc     <= insn_enc;
            trace_rs1     <= rs1;
            trace_cpr_pre <= snoop_data;  // Before any write
        end
        if (rsp_done) begin
            trace_result   <= cop_result;
            trace_wen      <= cop_wen;
            trace_waddr    <= cop_waddr;
            trace_wdata    <= cop_wdata;
            trace_cpr_post <= snoop_data; // Writeback already done
        end
    end

endmodule

// ==== verif/cop_cases.txt ====
// Columns: encoding, rs1, result, cop_wen, cop_waddr, cop_wdata, destination CPR after
// cop_waddr and cop_wdata are compared only where cop_wen is 1
0000100B 12345678 0 0 00 00000000 12345678
1001128B DEADBEEF 0 1 05 12345678 12345678
0000200B 0F0F00FF 0 0 00 00000000 0F0F00FF
2021300B 00000000 0 0 00 00000000 21435777
3021400B 00000000 0 0 00 00000000 1D3B5687
4081500B 00000000 0 0 00 00000000 78123456
4242600B 00000000 0 0 00 00000000 F0F0F00F
5FF3700B 00000000 0 0 00 00000000 21435876
5013300B 00000000 0 0 00 00000000 21435778
6002100B 55555555 1 0 00 00000000 12345678
F000218B 00000000 1 0 00 00000000 0F0F00FF
00004033 AAAAAAAA 1 0 00 00000000 1D3B5687
1001128A 00000000 1 0 00 00000000 12345678
10077F8B 00000000 0 1 1F 21435876 21435876
0000F00B 80000001 0 0 00 00000000 80000001
401FF00B 00000000 0 0 00 00000000 C0000000
20FF000B 00000000 0 0 00 00000000 80000000
1000008B 00000000 0 1 01 80000000 80000000

// ==== verif/tb_cop.sv ====
`timescale 1ns/1ps
`include "cop_config.svh"

module tb_cop;

    localparam int NUM_CASES      = 18;
    localparam int WORDS          = 7;                     // Columns per case line
    localparam int TIMEOUT_CYCLES = NUM_CASES * 12 + 50;

    logic                 g_clk;
    logic                 g_resetn;
    logic                 cpu_insn_req;
    logic [`COP_XLEN-1:0] cpu_insn_enc;
    logic [`COP_XLEN-1:0] cpu_rs1;
    logic                 cpu_insn_ack;
    logic                 cop_insn_ack;
    logic                 cop_insn_rsp;
    logic [2:0]           cop_result;
    logic                 cop_wen;
    logic [4:0]           cop_waddr;
    logic [`COP_XLEN-1:0] cop_wdata;
    logic                 trace_valid;
    logic [`COP_XLEN-1:0] trace_enc;
    logic [`COP_XLEN-1:0] trace_rs1;
    logic [2:0]           trace_result;
    logic                 trace_wen;
    logic [4:0]           trace_waddr;
    logic [`COP_XLEN-1:0] trace_wdata;
    logic [`COP_XLEN-1:0] trace_cpr_pre;
    logic [`COP_XLEN-1:0] trace_cpr_post;

    logic [31:0]          cases      [NUM_CASES*WORDS];
    logic [`COP_XLEN-1:0] cpr_model  [`COP_NUM_CPRS];  // CPR contents implied by the cases
    logic [`COP_XLEN-1:0] exp_pre    [NUM_CASES];
    logic [2:0]           ack_result [NUM_CASES];      // Response as first presented
    logic                 ack_wen    [NUM_CASES];
    logic [4:0]           ack_waddr  [NUM_CASES];
    logic [`COP_XLEN-1:0] ack_wdata  [NUM_CASES];

    int seed        = 14979;
    int errors      = 0;
    int checks      = 0;
    int cycle_count = 0;
    int rsp_count   = 0;   // Response handshakes so far
    int trace_count = 0;   // Trace pulses so far
    bit trace_due   = 1'b0;  // Handshake on the last edge, pulse expected now

    always #5 g_clk = ~g_clk;

    cop_top u_dut (.*);

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic present_request(input int k);
        cpu_insn_req = 1'b1;
        cpu_insn_enc = cases[k*WORDS];
        cpu_rs1      = cases[k*WORDS + 1];
    endtask

    // Response must not move while the CPU stalls
    task automatic check_held(input int k);
        check_value("cop_insn_rsp", 32'(cop_insn_rsp), 32'h1);
        check_value("cop_insn_ack", 32'(cop_insn_ack), 32'h0);  // Still busy
        check_value("cop_result", 32'(cop_result), 32'(ack_result[k]));
        check_value("cop_wen", 32'(cop_wen), 32'(ack_wen[k]));
        check_value("cop_waddr", 32'(cop_waddr), 32'(ack_waddr[k]));
        check_value("cop_wdata", cop_wdata, ack_wdata[k]);
    endtask

    task automatic check_trace(input int k);
        int base;
        base = k * WORDS;
        check_value("trace_enc", trace_enc, cases[base]);
        check_value("trace_rs1", trace_rs1, cases[base + 1]);
        check_value("trace_result", 32'(trace_result), 32'(ack_result[k]));
        check_value("trace_wen", 32'(trace_wen), 32'(ack_wen[k]));
        check_value("trace_waddr", 32'(trace_waddr), 32'(ack_waddr[k]));
        check_value("trace_wdata", trace_wdata, ack_wdata[k]);
        check_value("trace_cpr_pre", trace_cpr_pre, exp_pre[k]);
        check_value("trace_cpr_post", trace_cpr_post, cases[base + 6]);
        if (cases[base + 2] == 32'(cop_pkg::RES_ILLEGAL)) begin
            check_value("trace_cpr_post", trace_cpr_post, exp_pre[k]);  // Nothing written
        end
    endtask

    // One instruction, from request to response handshake
    task automatic run_case(input int k);
        int         base;
        int         delay;
        int         d;
        logic [3:0] crd;
        base = k * WORDS;
        crd  = cases[base][15:12];
        present_request(k);
        do begin
            @(negedge g_clk);
        end while (!cop_insn_ack);
        @(posedge g_clk);                  // Accept edge
        exp_pre[k] = cpr_model[crd];
        #1 cpu_insn_req = 1'b0;
        do begin
            @(negedge g_clk);
        end while (!cop_insn_rsp);
        ack_result[k] = cop_result;
        ack_wen[k]    = cop_wen;
        ack_waddr[k]  = cop_waddr;
        ack_wdata[k]  = cop_wdata;
        check_value("cop_result", 32'(cop_result), cases[base + 2]);
        check_value("cop_wen", 32'(cop_wen), cases[base + 3]);
        if (cases[base + 3][0]) begin      // GPR payload only matters when written
            check_value("cop_waddr", 32'(cop_waddr), cases[base + 4]);
            check_value("cop_wdata", cop_wdata, cases[base + 5]);
        end
        cpr_model[crd] = cases[base + 6];
        // Back-pressure, next request already waiting
        delay = int'({$random(seed)} % 4);
        for (d = 0; d < delay; d++) begin
            @(posedge g_clk);
            #1;
            if (k + 1 < NUM_CASES) begin
                present_request(k + 1);
            end
            @(negedge g_clk);
            check_held(k);
        end
        @(posedge g_clk);
        #1 cpu_insn_ack = 1'b1;
        @(negedge g_clk);
        check_held(k);
        @(posedge g_clk);                  // Response handshake edge
        rsp_count++;
        trace_due = 1'b1;
        #1 cpu_insn_ack = 1'b0;
    endtask

    // ----------------------------------------
    // Trace monitor and timeout
    // ----------------------------------------

    always @(negedge g_clk) begin
        if (g_resetn && trace_due && !trace_valid) begin
            errors++;
            $display("trace_valid did not pulse in the cycle after a response handshake");
        end
        trace_due = 1'b0;
        if (g_resetn && trace_valid) begin
            if (trace_count >= rsp_count) begin
                errors++;
                $display("trace_valid pulsed with no response handshake pending");
            end else begin
                check_trace(trace_count);
                trace_count++;
            end
        end
    end

    always @(posedge g_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the cases did not all complete", cycle_count);
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("Checks failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        int k;
        g_clk        = 1'b0;
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        cpu_insn_ack = 1'b0;
        for (k = 0; k < `COP_NUM_CPRS; k++) begin
            cpr_model[k] = '0;             // CPRs clear out of reset
        end
        $readmemh("verif/cop_cases.txt", cases);
        if ($isunknown(cases[NUM_CASES*WORDS - 1])) begin
            errors++;
            $display("Case file verif/cop_cases.txt is missing or too short");
        end
        repeat (5) @(posedge g_clk);
        #1 g_resetn = 1'b1;
        repeat (3) begin                   // Idle with no request
            @(negedge g_clk);
            check_value("cop_insn_rsp", 32'(cop_insn_rsp), 32'h0);
            check_value("trace_valid", 32'(trace_valid), 32'h0);
            check_value("cop_insn_ack", 32'(cop_insn_ack), 32'h0);
        end
        @(posedge g_clk);
        #1;
        for (k = 0; k < NUM_CASES; k++) begin
            run_case(k);
        end
        repeat (3) @(negedge g_clk);       // Last trace pulse
        if (trace_count != NUM_CASES) begin
            errors++;
            $display("Saw %0d trace pulses for %0d responses", trace_count, NUM_CASES);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
